//--- Makefile
SIM      := verilator
TOP      := usb_loopback_tb
FILELIST := files.f
FLAGS    := --binary --timing --assert -j 0
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- files.f
+incdir+hdl
hdl/usb_loop_pkg.sv
hdl/sync_fifo.sv
hdl/bulk_endpoint_ctrl.sv
hdl/status_reporter.sv
hdl/uart_tx.sv
hdl/usb_loopback_top.sv
tests/usb_loopback_assert.sv
tests/usb_loopback_tb.sv

//--- hdl/bulk_endpoint_ctrl.sv
`timescale 1ns/1ps
`include "usb_loop_macros.svh"
module bulk_endpoint_ctrl (
  input  logic                      clock,
  input  logic                      usb_reset,

  input  logic                      configured_i,
  input  logic                      blk_cycle_i,
  input  usb_loop_pkg::fifo_level_t level_i,

  // OUT stream from the USB core into the FIFO
  input  logic                      out_valid_i,
  output logic                      out_ready_o,
  output logic                      fifo_push_valid_o,
  input  logic                      fifo_push_ready_i,

  // IN stream from the FIFO back to the USB core
  input  logic                      fifo_pop_valid_i,
  output logic                      fifo_pop_ready_o,
  output logic                      in_valid_o,
  input  logic                      in_ready_i,

  // Endpoint status flags to the USB core
  output logic                      blk_in_ready_o,
  output logic                      blk_out_ready_o
);

  import usb_loop_pkg::*;

  localparam fifo_level_t IN_MIN  = fifo_level_t'(`IN_READY_MIN);
  localparam fifo_level_t OUT_MAX = fifo_level_t'(`OUT_READY_MAX);

  logic in_avail;
  logic out_space;

  // Enough buffered data to start an IN transfer
  assign in_avail  = configured_i && (level_i > IN_MIN);
  // Room left for a full OUT packet
  assign out_space = configured_i && (level_i < OUT_MAX);

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      blk_in_ready_o  <= 1'b0;
      blk_out_ready_o <= 1'b0;
    end else begin
      blk_in_ready_o  <= in_avail;
      blk_out_ready_o <= out_space;
    end
  end

  // Core only moves bulk data during its block cycle
  assign fifo_push_valid_o = out_valid_i && blk_cycle_i;
  assign out_ready_o       = fifo_push_ready_i && blk_cycle_i;

  // IN side stalls in the FIFO output stage outside the block cycle
  assign in_valid_o       = fifo_pop_valid_i && blk_cycle_i;
  assign fifo_pop_ready_o = in_ready_i && blk_cycle_i;

endmodule

//--- hdl/status_reporter.sv
`timescale 1ns/1ps
`include "usb_loop_macros.svh"
module status_reporter (
  input  logic                       clock,
  input  logic                       usb_reset,

  input  logic                       configured_i,
  input  logic                       sof_i,
  input  logic                       crc_err_i,
  input  logic                       timeout_i,

  output logic                       rec_valid_o,
  input  logic                       rec_ready_i,
  output usb_loop_pkg::status_byte_t rec_data_o,

  output logic [1:0]                 err_leds_o
);

  import usb_loop_pkg::*;

  typedef enum logic {
    REC_HEAD,
    REC_COUNT
  } rec_state_t;

  rec_state_t    state_q;
  logic          sof_q;
  logic [7:0]    frame_cnt;
  logic [7:0]    frame_next;
  logic          crc_err_q;
  logic          timeout_q;
  status_byte_t  count_snap_q;
  status_flags_t flags;
  status_byte_t  header;

  logic sof_rise;
  logic report_due;
  logic rec_start;
  logic rec_xfer;

  assign sof_rise   = sof_i && !sof_q;
  assign frame_next = frame_cnt + 8'd1;
  assign report_due = sof_rise && ((frame_next % `REPORT_FRAMES) == 0);
  // A record still queueing swallows this report
  assign rec_start  = report_due && !rec_valid_o;
  assign rec_xfer   = rec_valid_o && rec_ready_i;

  assign flags  = '{configured: configured_i, timeout: timeout_q, crc_err: crc_err_q};
  assign header = STATUS_HEADER | {4'b0000, flags, 1'b0};

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      sof_q       <= 1'b0;
      frame_cnt   <= '0;
      crc_err_q   <= 1'b0;
      timeout_q   <= 1'b0;
      rec_valid_o <= 1'b0;
      state_q     <= REC_HEAD;
    end else begin
      sof_q <= sof_i;
      if (sof_rise) begin
        frame_cnt <= frame_next;
      end
      // Sticky until reset
      if (crc_err_i) begin
        crc_err_q <= 1'b1;
      end
      if (timeout_i) begin
        timeout_q <= 1'b1;
      end

      if (rec_start) begin
        rec_valid_o <= 1'b1;
      end else if (rec_xfer) begin
        if (state_q == REC_HEAD) begin
          state_q <= REC_COUNT;
        end else begin
          state_q     <= REC_HEAD;
          rec_valid_o <= 1'b0;
        end
      end
    end
  end

  // Count byte is frozen at the report edge
  always_ff @(posedge clock) begin
    if (rec_start) begin
      rec_data_o   <= header;
      count_snap_q <= frame_next;
    end else if (rec_xfer && state_q == REC_HEAD) begin
      rec_data_o <= count_snap_q;
    end
  end

  assign err_leds_o = {crc_err_q, timeout_q};

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps
module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  ABITS     = 4
) (
  input  logic                      clock,
  input  logic                      usb_reset,

  input  logic                      valid_i,
  output logic                      ready_o,
  input  payload_t                  data_i,

  output logic                      valid_o,
  input  logic                      ready_i,
  output payload_t                  data_o,

  output usb_loop_pkg::fifo_level_t level_o
);

  import usb_loop_pkg::*;

  localparam int DEPTH = 1 << ABITS;

  payload_t mem [DEPTH];

  logic [ABITS-1:0] wr_ptr;
  logic [ABITS-1:0] rd_ptr;
  logic [ABITS:0]   ram_count;
  logic [ABITS:0]   ram_count_next;

  logic push;
  logic pop;
  logic load;
  logic ram_empty;
  logic bypass;
  logic ram_wr;
  logic ram_rd;

  assign push      = valid_i && ready_o;
  assign pop       = valid_o && ready_i;
  // Output stage can take a new entry this cycle
  assign load      = !valid_o || pop;
  assign ram_empty = (ram_count == '0);
  // Empty RAM, so the incoming beat goes straight to the output stage
  assign bypass    = push && load && ram_empty;
  assign ram_wr    = push && !bypass;
  assign ram_rd    = load && !ram_empty;

  always_comb begin
    ram_count_next = ram_count;
    if (ram_wr) begin
      ram_count_next = ram_count_next + 1'b1;
    end
    if (ram_rd) begin
      ram_count_next = ram_count_next - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      ram_count <= '0;
      ready_o   <= 1'b0;
      valid_o   <= 1'b0;
    end else begin
      ram_count <= ram_count_next;
      // MSB set means exactly DEPTH entries stored
      ready_o   <= !ram_count_next[ABITS];
      if (ram_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (ram_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (load) begin
        valid_o <= !ram_empty || push;
      end
    end
  end

  // Storage and output data
  always_ff @(posedge clock) begin
    if (ram_wr) begin
      mem[wr_ptr] <= data_i;
    end
    if (load) begin
      if (!ram_empty) begin
        data_o <= mem[rd_ptr];
      end else if (push) begin
        data_o <= data_i;
      end
    end
  end

  // Output stage counts as one stored entry
  assign level_o = fifo_level_t'(ram_count) + fifo_level_t'(valid_o);

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ps
`include "usb_loop_macros.svh"
module uart_tx (
  input  logic                       clock,
  input  logic                       usb_reset,

  input  logic                       valid_i,
  output logic                       ready_o,
  input  usb_loop_pkg::status_byte_t data_i,

  output logic                       txd_o
);

  localparam int CLKS = `UART_CLKS_PER_BIT;
  localparam int CW   = $clog2(CLKS + 1);

  // Stop, data LSB first, start; shifted out from bit 0
  logic [9:0]    shift_q;
  logic [CW-1:0] clk_cnt;
  logic [3:0]    bit_idx;
  logic          busy_q;

  logic take;
  logic bit_end;

  assign ready_o = !busy_q;
  assign take    = valid_i && ready_o;
  assign bit_end = (clk_cnt == CW'(CLKS - 1));

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      shift_q <= '1;
      clk_cnt <= '0;
      bit_idx <= '0;
      busy_q  <= 1'b0;
    end else if (!busy_q) begin
      if (take) begin
        shift_q <= {1'b1, data_i, 1'b0};
        clk_cnt <= '0;
        bit_idx <= '0;
        busy_q  <= 1'b1;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      // Ones shift in, so the line rests high once done
      shift_q <= {1'b1, shift_q[9:1]};
      if (bit_idx == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        bit_idx <= bit_idx + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  assign txd_o = shift_q[0];

endmodule

//--- hdl/usb_loop_macros.svh
`ifndef USB_LOOP_MACROS_SVH
`define USB_LOOP_MACROS_SVH

// Loop-back FIFO RAM is 2**11 entries, plus the output stage
`define BULK_FIFO_ABITS 11

// Status FIFO only ever holds a few records
`define STATUS_FIFO_ABITS 4

// Endpoint flag thresholds, in stored bytes
`define IN_READY_MIN 4
`define OUT_READY_MAX 1024

// SOF rising edges per status record
`define REPORT_FRAMES 4

// Clock cycles per serial bit, short for simulation
`define UART_CLKS_PER_BIT 8

`endif

//--- hdl/usb_loop_pkg.sv
package usb_loop_pkg;

  // One bulk byte with its end-of-packet marker
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } bulk_beat_t;

  // One byte of the serial status record
  typedef logic [7:0] status_byte_t;

  // Fill count, covers 2048 RAM entries plus the output stage
  typedef logic [11:0] fifo_level_t;

  // Lands in bits 3..1 of the header byte
  typedef struct packed {
    logic configured;
    logic timeout;
    logic crc_err;
  } status_flags_t;

  // Header byte with the flag bits still clear
  localparam status_byte_t STATUS_HEADER = 8'hA0;

endpackage

//--- hdl/usb_loopback_top.sv
`timescale 1ns/1ps
`include "usb_loop_macros.svh"
module usb_loopback_top (
  input  logic       clock,
  input  logic       usb_reset_i,

  // Status from the USB core
  input  logic       configured_i,
  input  logic       blk_cycle_i,
  input  logic       sof_i,
  input  logic       crc_err_i,
  input  logic       timeout_i,

  // Bulk OUT stream
  input  logic       out_valid_i,
  output logic       out_ready_o,
  input  logic       out_last_i,
  input  logic [7:0] out_data_i,

  // Bulk IN stream
  output logic       in_valid_o,
  input  logic       in_ready_i,
  output logic       in_last_o,
  output logic [7:0] in_data_o,

  output logic       blk_in_ready_o,
  output logic       blk_out_ready_o,
  output logic [3:0] leds_o,
  output logic       uart_tx_o
);

  import usb_loop_pkg::*;

  bulk_beat_t   out_beat;
  bulk_beat_t   in_beat;
  fifo_level_t  bulk_level;
  logic         push_valid, push_ready, pop_valid, pop_ready;
  logic         rec_valid, rec_ready;
  status_byte_t rec_data;
  logic         tx_valid, tx_ready;
  status_byte_t tx_data;
  logic [1:0]   err_leds;

  assign out_beat = '{last: out_last_i, data: out_data_i};
  assign in_last_o = in_beat.last;
  assign in_data_o = in_beat.data;
  assign leds_o    = {err_leds, blk_in_ready_o, blk_out_ready_o};

  sync_fifo #(.payload_t(bulk_beat_t), .ABITS(`BULK_FIFO_ABITS)) u_bulk_fifo (
    .clock(clock), .usb_reset(usb_reset_i),
    .valid_i(push_valid), .ready_o(push_ready), .data_i(out_beat),
    .valid_o(pop_valid), .ready_i(pop_ready), .data_o(in_beat),
    .level_o(bulk_level)
  );

  bulk_endpoint_ctrl u_ep_ctrl (
    .clock(clock), .usb_reset(usb_reset_i),
    .configured_i(configured_i), .blk_cycle_i(blk_cycle_i), .level_i(bulk_level),
    .out_valid_i(out_valid_i), .out_ready_o(out_ready_o),
    .fifo_push_valid_o(push_valid), .fifo_push_ready_i(push_ready),
    .fifo_pop_valid_i(pop_valid), .fifo_pop_ready_o(pop_ready),
    .in_valid_o(in_valid_o), .in_ready_i(in_ready_i),
    .blk_in_ready_o(blk_in_ready_o), .blk_out_ready_o(blk_out_ready_o)
  );

  status_reporter u_status (
    .clock(clock), .usb_reset(usb_reset_i),
    .configured_i(configured_i), .sof_i(sof_i),
    .crc_err_i(crc_err_i), .timeout_i(timeout_i),
    .rec_valid_o(rec_valid), .rec_ready_i(rec_ready), .rec_data_o(rec_data),
    .err_leds_o(err_leds)
  );

  sync_fifo #(.payload_t(status_byte_t), .ABITS(`STATUS_FIFO_ABITS)) u_status_fifo (
    .clock(clock), .usb_reset(usb_reset_i),
    .valid_i(rec_valid), .ready_o(rec_ready), .data_i(rec_data),
    .valid_o(tx_valid), .ready_i(tx_ready), .data_o(tx_data),
    .level_o()
  );

  uart_tx u_uart_tx (
    .clock(clock), .usb_reset(usb_reset_i),
    .valid_i(tx_valid), .ready_o(tx_ready), .data_i(tx_data),
    .txd_o(uart_tx_o)
  );

endmodule

//--- tests/usb_loopback_assert.sv
`timescale 1ns/1ps
module usb_loopback_assert (
  input logic                      clock,
  input logic                      usb_reset,
  input logic                      configured_i,
  input logic                      blk_cycle_i,
  input usb_loop_pkg::fifo_level_t level_i,
  input logic                      out_valid_i,
  input logic                      out_ready_o,
  input logic                      fifo_pop_valid_i,
  input logic                      fifo_pop_ready_o,
  input logic                      blk_in_ready_o,
  input logic                      blk_out_ready_o
);

  // OUT valid from the core holds until accepted
  out_valid_hold: assert property (@(posedge clock) disable iff (usb_reset)
    out_valid_i && !out_ready_o |=> out_valid_i)
    else $error("out_valid_i dropped before its beat transferred");

  // FIFO output waits through IN and block-cycle stalls
  pop_valid_hold: assert property (@(posedge clock) disable iff (usb_reset)
    fifo_pop_valid_i && !fifo_pop_ready_o |=> fifo_pop_valid_i)
    else $error("FIFO pop valid dropped before its beat transferred");

  // Nothing enters or leaves the FIFO outside the block cycle
  no_move_outside_cycle: assert property (@(posedge clock) disable iff (usb_reset)
    !blk_cycle_i |=> $stable(level_i))
    else $error("FIFO level moved outside the block cycle");

  // Registered flags follow one edge behind
  flags_drop: assert property (@(posedge clock) disable iff (usb_reset)
    $fell(configured_i) |=> !blk_in_ready_o && !blk_out_ready_o)
    else $error("endpoint flags still high after configured_i fell");

endmodule

bind bulk_endpoint_ctrl usb_loopback_assert u_assert (.*);

//--- tests/usb_loopback_tb.sv
`timescale 1ns/1ps
`include "usb_loop_macros.svh"
module usb_loopback_tb;

  import usb_loop_pkg::*;

  localparam int NUM_TESTS = 7;
  localparam int CLKS      = `UART_CLKS_PER_BIT;

  typedef struct packed {
    logic [11:0] len;
    logic        cfg;
    logic [1:0]  stall;
    logic        hold;
    logic [7:0]  sofs;
    logic        crc;
    logic        tmo;
  } test_row_t;

  logic       clock;
  logic       usb_reset_i;
  logic       configured_i;
  logic       blk_cycle_i;
  logic       sof_i;
  logic       crc_err_i;
  logic       timeout_i;
  logic       out_valid_i;
  logic       out_ready_o;
  logic       out_last_i;
  logic [7:0] out_data_i;
  logic       in_valid_o;
  logic       in_ready_i;
  logic       in_last_o;
  logic [7:0] in_data_o;
  logic       blk_in_ready_o;
  logic       blk_out_ready_o;
  logic [3:0] leds_o;
  logic       uart_tx_o;

  test_row_t    rows [NUM_TESTS];
  bulk_beat_t   exp_q [$];
  bulk_beat_t   cur_beat;
  status_byte_t exp_status_q [$];
  status_byte_t uart_q [$];
  logic [31:0]  lfsr = 32'hda85;
  int           sent;
  int           frame_total;
  int           errors;
  int           uart_errors;
  int           tests_failed;
  bit           crc_seen;
  bit           tmo_seen;
  bit           timed_out;
  bit           rx_busy;
  int           rx_cnt;
  int           rx_idx;
  logic [7:0]   rx_shift;

  usb_loopback_top dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Serial decoder, samples near the middle of each bit
  always @(negedge clock) begin
    if (usb_reset_i === 1'b1) begin
      rx_busy = 1'b0;
    end else if (!rx_busy) begin
      if (uart_tx_o === 1'b0) begin
        rx_busy = 1'b1;
        rx_cnt  = 0;
        rx_idx  = 0;
      end
    end else begin
      rx_cnt++;
      if (rx_cnt == CLKS / 2 + CLKS * rx_idx) begin
        if (rx_idx == 0 && uart_tx_o !== 1'b0) begin
          $display("UART start bit did not stay low at %0t", $time);
          uart_errors++;
          rx_busy = 1'b0;
        end else if (rx_idx >= 1 && rx_idx <= 8) begin
          rx_shift = {uart_tx_o, rx_shift[7:1]};
        end else if (rx_idx == 9) begin
          if (uart_tx_o !== 1'b1) begin
            $display("UART stop bit missing at %0t", $time);
            uart_errors++;
          end else begin
            uart_q.push_back(rx_shift);
          end
          rx_busy = 1'b0;
        end
        rx_idx++;
      end
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[6:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  task automatic check_beat(input bulk_beat_t got, input bulk_beat_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: IN beat %02h last %0b, expected %02h last %0b",
               $time, got.data, got.last, exp.data, exp.last);
      errors++;
    end
  endtask

  task automatic check_status(input status_byte_t got, input status_byte_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: status byte %02h, expected %02h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %0b, expected %0b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input int t, input string what);
    $display("Timeout in test %0d while %s", t, what);
    timed_out = 1'b1;
    tests_failed++;
  endtask

  // Sample at the falling edge, drive just after the rising edge
  task automatic stream_cycle(input int len, input int stall, input bit drain);
    logic       out_xfer;
    bulk_beat_t got;
    @(negedge clock);
    if (!blk_cycle_i) begin
      check_flag(out_ready_o, 1'b0, "out_ready_o outside block cycle");
      check_flag(in_valid_o, 1'b0, "in_valid_o outside block cycle");
    end
    out_xfer = out_valid_i && out_ready_o;
    if (out_xfer) begin
      exp_q.push_back(cur_beat);
      sent++;
    end
    if (in_valid_o && in_ready_i) begin
      got = '{last: in_last_o, data: in_data_o};
      if (exp_q.size() == 0) begin
        $display("[ERROR] %0t: IN beat %02h arrived with nothing expected", $time, in_data_o);
        errors++;
      end else begin
        check_beat(got, exp_q.pop_front());
      end
    end
    @(posedge clock);
    #1;
    if (out_xfer || !out_valid_i) begin
      if (sent < len) begin
        cur_beat.data = rand_bits(8);
        cur_beat.last = (sent == len - 1);
        out_valid_i   = 1'b1;
      end else begin
        out_valid_i = 1'b0;
      end
      out_data_i = cur_beat.data;
      out_last_i = cur_beat.last;
    end
    blk_cycle_i = int'(rand_bits(2)) >= stall;
    in_ready_i  = drain && (int'(rand_bits(2)) >= stall);
  endtask

  task automatic run_test(input int t);
    test_row_t     row;
    int            len;
    int            stall;
    int            limit;
    int            cycles;
    int            errs_before;
    status_flags_t flags;
    status_byte_t  exp_hdr;
    logic          exp_in_rdy;
    logic          exp_out_rdy;
    row         = rows[t];
    len         = int'(row.len);
    stall       = int'(row.stall);
    limit       = 64 * len + 500;
    cycles      = 0;
    sent        = 0;
    errs_before = errors + uart_errors;
    @(posedge clock);
    #1;
    configured_i = row.cfg;
    crc_err_i    = row.crc;
    timeout_i    = row.tmo;
    @(posedge clock);
    #1;
    crc_err_i = 1'b0;
    timeout_i = 1'b0;
    crc_seen  = crc_seen | row.crc;
    tmo_seen  = tmo_seen | row.tmo;

    // Fill without draining, then check the flags at a known level
    if (row.hold) begin
      while (sent < len && cycles <= limit) begin
        stream_cycle(len, stall, 1'b0);
        cycles++;
      end
      if (cycles > limit) begin
        report_timeout(t, "filling the loop-back FIFO");
        return;
      end
      repeat (2) @(negedge clock);
      exp_in_rdy  = row.cfg && (len > `IN_READY_MIN);
      exp_out_rdy = row.cfg && (len < `OUT_READY_MAX);
      check_flag(blk_in_ready_o, exp_in_rdy, "blk_in_ready_o after fill");
      check_flag(blk_out_ready_o, exp_out_rdy, "blk_out_ready_o after fill");
      check_flag(leds_o[1], exp_in_rdy, "IN ready LED after fill");
      check_flag(leds_o[0], exp_out_rdy, "OUT ready LED after fill");
    end
    while ((sent < len || exp_q.size() != 0) && cycles <= limit) begin
      stream_cycle(len, stall, 1'b1);
      cycles++;
    end
    if (cycles > limit) begin
      report_timeout(t, "looping the packet back");
      return;
    end
    blk_cycle_i = 1'b1;
    in_ready_i  = 1'b0;
    repeat (2) @(negedge clock);
    check_flag(blk_in_ready_o, 1'b0, "blk_in_ready_o when empty");
    check_flag(blk_out_ready_o, row.cfg, "blk_out_ready_o when empty");

    // SOF pulses, one record per REPORT_FRAMES rising edges
    @(posedge clock);
    #1;
    for (int i = 0; i < int'(row.sofs); i++) begin
      sof_i = 1'b1;
      @(posedge clock);
      #1;
      sof_i = 1'b0;
      repeat (3) @(posedge clock);
      #1;
      frame_total++;
      if (frame_total % `REPORT_FRAMES == 0) begin
        flags        = '{configured: row.cfg, timeout: tmo_seen, crc_err: crc_seen};
        exp_hdr      = 8'hA0;
        exp_hdr[3:1] = flags;
        exp_status_q.push_back(exp_hdr);
        exp_status_q.push_back(status_byte_t'(frame_total % 256));
      end
    end
    cycles = 0;
    while (uart_q.size() < exp_status_q.size() && cycles < 100 * exp_status_q.size() + 200) begin
      @(posedge clock);
      cycles++;
    end
    if (uart_q.size() < exp_status_q.size()) begin
      report_timeout(t, "waiting for the status record on the UART");
      return;
    end
    while (exp_status_q.size() != 0) begin
      check_status(uart_q.pop_front(), exp_status_q.pop_front());
    end
    check_flag(leds_o[3], crc_seen, "CRC error LED");
    check_flag(leds_o[2], tmo_seen, "timeout LED");

    if (errors + uart_errors == errs_before) begin
      $display("test %0d (len %0d): ok", t, len);
    end else begin
      tests_failed++;
      $display("test %0d (len %0d): FAILED, %0d errors", t, len,
               errors + uart_errors - errs_before);
    end
  endtask

  initial begin
    usb_reset_i  = 1'b1;
    configured_i = 1'b0;
    blk_cycle_i  = 1'b0;
    sof_i        = 1'b0;
    crc_err_i    = 1'b0;
    timeout_i    = 1'b0;
    out_valid_i  = 1'b0;
    out_last_i   = 1'b0;
    out_data_i   = '0;
    in_ready_i   = 1'b0;
    // len, configured, stall, hold, SOF pulses, CRC strobe, timeout strobe
    rows[0] = '{12'd16, 1'b1, 2'd1, 1'b0, 8'd4, 1'b0, 1'b0};
    rows[1] = '{12'd64, 1'b1, 2'd2, 1'b0, 8'd8, 1'b0, 1'b0};
    rows[2] = '{12'd4, 1'b1, 2'd0, 1'b1, 8'd0, 1'b0, 1'b0};
    rows[3] = '{12'd5, 1'b1, 2'd1, 1'b1, 8'd4, 1'b1, 1'b0};
    rows[4] = '{12'd1024, 1'b1, 2'd1, 1'b1, 8'd0, 1'b0, 1'b1};
    rows[5] = '{12'd40, 1'b0, 2'd2, 1'b1, 8'd4, 1'b0, 1'b0};
    rows[6] = '{12'd100, 1'b1, 2'd3, 1'b0, 8'd4, 1'b0, 1'b0};
    repeat (8) @(posedge clock);
    #1;
    usb_reset_i = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
      if (timed_out) begin
        break;
      end
    end
    $display("tests failed %0d of %0d, errors %0d", tests_failed, NUM_TESTS,
             errors + uart_errors);
    if (errors + uart_errors == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
